// ==== verilog/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

  // datapath and operand widths
  localparam int XLEN    = 64;
  localparam int SHAMT_W = 6;     // rv64 shift amount
  localparam int TAG_W   = 4;

  // request queue sizing, upstream starts with one credit per entry
  localparam int REQ_DEPTH = 4;
  localparam int REQ_PTR_W = $clog2(REQ_DEPTH);
  localparam int REQ_CNT_W = $clog2(REQ_DEPTH + 1);

  // downstream credits held after reset
  localparam int RESP_CREDITS = 2;
  localparam int RESP_CNT_W   = $clog2(RESP_CREDITS + 1);

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    SLL  = 4'd2,
    SRL  = 4'd3,
    SRA  = 4'd4,
    AND  = 4'd5,
    OR   = 4'd6,
    XOR  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9
  } alu_op_e;

  // shift view of operand b, upper bits ignored
  typedef struct packed {
    logic [XLEN-SHAMT_W-1:0] pad;
    logic [SHAMT_W-1:0]      shamt;
  } alu_shift_view_t;

  // operand b is either a full value or a shift amount
  typedef union packed {
    logic [XLEN-1:0] value;
    alu_shift_view_t shift;
  } alu_operand_u;

  typedef struct packed {
    alu_op_e         op;
    logic [XLEN-1:0] a;
    alu_operand_u    b;
    logic [TAG_W-1:0] tag;
  } alu_req_t;

  typedef struct packed {
    logic zf;   // sum is zero
    logic cf;   // carry, or borrow on subtract
    logic of;   // signed overflow
    logic sf;   // sign of sum
  } alu_flags_t;

  typedef struct packed {
    logic [XLEN-1:0]  result;
    alu_flags_t       flags;
    logic [TAG_W-1:0] tag;
  } alu_resp_t;

endpackage

`default_nettype wire

// ==== verilog/alu_adder.sv ====
`default_nettype none

module alu_adder (
  input  logic [alu_pkg::XLEN-1:0] a_i,
  input  logic [alu_pkg::XLEN-1:0] b_i,
  input  logic                     sub_i,
  output logic [alu_pkg::XLEN-1:0] sum_o,
  output alu_pkg::alu_flags_t      flags_o,
  output logic                     lt_signed_o,
  output logic                     lt_unsigned_o
);

  localparam int W = alu_pkg::XLEN;

  logic [W:0] a_ext;     // doubled sign bit
  logic [W:0] b_ext;
  logic [W:0] sum_ext;
  logic       carry_out;
  logic       ovf;

  assign a_ext = {a_i[W-1], a_i};
  assign b_ext = {b_i[W-1], b_i} ^ {(W + 1){sub_i}};   // invert b for subtract

  // carry in of one completes the two's complement
  assign sum_ext = a_ext + b_ext + {{W{1'b0}}, sub_i};

  // the top bit of the extended sum is a ^ b ^ carry, so the
  // true carry out of bit 63 falls out of the extension bits
  assign carry_out = sum_ext[W] ^ a_ext[W] ^ b_ext[W];

  assign ovf = sum_ext[W] ^ sum_ext[W-1];   // sign bits disagree

  assign sum_o = sum_ext[W-1:0];

  always_comb begin
    flags_o.zf = (sum_ext[W-1:0] == '0);
    flags_o.cf = carry_out ^ sub_i;          // borrow when subtracting
    flags_o.of = ovf;
    flags_o.sf = sum_ext[W-1];
  end

  assign lt_signed_o   = ovf ^ sum_ext[W-1];
  assign lt_unsigned_o = carry_out ^ sub_i;  // a < b unsigned iff borrow

endmodule

`default_nettype wire

// ==== verilog/alu_shifter.sv ====
`default_nettype none

module alu_shifter (
  input  alu_pkg::alu_op_e            op_i,
  input  logic [alu_pkg::XLEN-1:0]    a_i,
  input  logic [alu_pkg::SHAMT_W-1:0] shamt_i,
  output logic [alu_pkg::XLEN-1:0]    res_o
);

  localparam int W = alu_pkg::XLEN;

  logic         is_sll;
  logic         is_srl;
  logic         is_sra;
  logic         is_right;
  logic         is_shift;
  logic [W-1:0] shift_in;
  logic [W-1:0] shifted;
  logic [W-1:0] right_res;
  logic [W-1:0] mask;
  logic [W-1:0] sra_res;

  // bit reversal, plain rewiring
  function automatic logic [W-1:0] bit_rev(input logic [W-1:0] v);
    logic [W-1:0] r;
    for (int i = 0; i < W; i++) begin
      r[i] = v[W-1-i];
    end
    return r;
  endfunction

  assign is_sll   = (op_i == alu_pkg::SLL);
  assign is_srl   = (op_i == alu_pkg::SRL);
  assign is_sra   = (op_i == alu_pkg::SRA);
  assign is_right = is_srl | is_sra;
  assign is_shift = is_sll | is_right;

  // right shifts go through the same left shifter on reversed data
  assign shift_in  = {W{is_shift}} & (is_right ? bit_rev(a_i) : a_i);   // quiet when unused
  assign shifted   = shift_in << shamt_i;
  assign right_res = bit_rev(shifted);

  // ones where real data landed, sign fills the rest
  assign mask    = {W{1'b1}} >> shamt_i;
  assign sra_res = (right_res & mask) | ({W{a_i[W-1]}} & ~mask);

  always_comb begin
    if (is_sra) begin
      res_o = sra_res;
    end else if (is_srl) begin
      res_o = right_res;
    end else begin
      res_o = shifted;    // sll, or zero for other ops
    end
  end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`default_nettype none

module alu (
  input  alu_pkg::alu_req_t         req_i,
  output logic [alu_pkg::XLEN-1:0]  result_o,
  output alu_pkg::alu_flags_t       flags_o
);

  localparam int W = alu_pkg::XLEN;

  logic                sub;
  logic                uses_adder;
  logic [W-1:0]        sum;
  alu_pkg::alu_flags_t add_flags;
  logic                lt_signed;
  logic                lt_unsigned;
  logic [W-1:0]        shift_res;

  // compares are a subtract with the result thrown away
  assign sub = (req_i.op == alu_pkg::SUB) ||
               (req_i.op == alu_pkg::SLT) ||
               (req_i.op == alu_pkg::SLTU);

  assign uses_adder = sub || (req_i.op == alu_pkg::ADD);

  alu_adder u_adder (
    .a_i           (req_i.a),
    .b_i           (req_i.b.value),
    .sub_i         (sub),
    .sum_o         (sum),
    .flags_o       (add_flags),
    .lt_signed_o   (lt_signed),
    .lt_unsigned_o (lt_unsigned)
  );

  alu_shifter u_shifter (
    .op_i    (req_i.op),
    .a_i     (req_i.a),
    .shamt_i (req_i.b.shift.shamt),   // low 6 bits only
    .res_o   (shift_res)
  );

  always_comb begin
    case (req_i.op)
      alu_pkg::ADD,
      alu_pkg::SUB:  result_o = sum;
      alu_pkg::SLL,
      alu_pkg::SRL,
      alu_pkg::SRA:  result_o = shift_res;
      alu_pkg::AND:  result_o = req_i.a & req_i.b.value;
      alu_pkg::OR:   result_o = req_i.a | req_i.b.value;
      alu_pkg::XOR:  result_o = req_i.a ^ req_i.b.value;
      alu_pkg::SLT:  result_o = {{(W - 1){1'b0}}, lt_signed};
      alu_pkg::SLTU: result_o = {{(W - 1){1'b0}}, lt_unsigned};
      default:       result_o = '0;   // unused encodings
    endcase
  end

  // logic and shift ops report clean flags
  assign flags_o = uses_adder ? add_flags : '0;

endmodule

`default_nettype wire

// ==== verilog/req_fifo.sv ====
`default_nettype none

module req_fifo (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              push_i,
  input  alu_pkg::alu_req_t data_i,
  input  logic              pop_i,
  output alu_pkg::alu_req_t head_o,
  output logic              not_empty_o,
  output logic              credit_o
);

  localparam int PW = alu_pkg::REQ_PTR_W;
  localparam int CW = alu_pkg::REQ_CNT_W;

  alu_pkg::alu_req_t mem [alu_pkg::REQ_DEPTH];
  logic [PW-1:0]     wr_ptr;
  logic [PW-1:0]     rd_ptr;
  logic [CW-1:0]     count;

  // storage only, validity comes from count
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_o <= 1'b0;
    end else begin
      credit_o <= pop_i;   // one credit back per removed entry
      if (push_i) begin
        wr_ptr <= (wr_ptr == PW'(alu_pkg::REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= (rd_ptr == PW'(alu_pkg::REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // both or neither
      endcase
    end
  end

  assign head_o      = mem[rd_ptr];
  assign not_empty_o = (count != '0);

endmodule

`default_nettype wire

// ==== verilog/exec_unit.sv ====
`default_nettype none

module exec_unit (
  input  logic               clk_i,
  input  logic               reset_i,
  // upstream issue side
  input  logic               req_valid_i,
  input  alu_pkg::alu_req_t  req_i,
  output logic               req_credit_o,
  // downstream result side
  output logic               resp_valid_o,
  output alu_pkg::alu_resp_t resp_o,
  input  logic               resp_credit_i
);

  localparam int RCW = alu_pkg::RESP_CNT_W;

  alu_pkg::alu_req_t          head;
  logic                       fifo_not_empty;
  logic                       pop;
  logic [alu_pkg::XLEN-1:0]   alu_result;
  alu_pkg::alu_flags_t        alu_flags;
  logic [RCW-1:0]             resp_credits;
  alu_pkg::alu_resp_t         resp_q;
  logic                       resp_valid_q;

  req_fifo u_req_fifo (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_i      (req_valid_i),    // upstream credits guarantee room
    .data_i      (req_i),
    .pop_i       (pop),
    .head_o      (head),
    .not_empty_o (fifo_not_empty),
    .credit_o    (req_credit_o)
  );

  alu u_alu (
    .req_i    (head),
    .result_o (alu_result),
    .flags_o  (alu_flags)
  );

  // issue whenever there is work and somewhere to send it
  assign pop = fifo_not_empty && (resp_credits != '0);

  // downstream credit counter
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_credits <= RCW'(alu_pkg::RESP_CREDITS);
    end else begin
      case ({resp_credit_i, pop})
        2'b10:   resp_credits <= resp_credits + 1'b1;
        2'b01:   resp_credits <= resp_credits - 1'b1;
        default: resp_credits <= resp_credits;   // return and send cancel
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= pop;
    end
  end

  // payload only moves on pop
  always_ff @(posedge clk_i) begin
    if (pop) begin
      resp_q.result <= alu_result;
      resp_q.flags  <= alu_flags;
      resp_q.tag    <= head.tag;   // tag rides through untouched
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

endmodule

`default_nettype wire

// ==== verification/clock_gen.sv ====
`default_nettype none

module clock_gen (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 1ns;

  localparam int HALF_PERIOD = 50;   // 100 ns period

  initial begin
    clk_o = 1'b0;
  end

  always begin
    #HALF_PERIOD clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// ==== verification/exec_unit_assert.sv ====
`default_nettype none

module exec_unit_assert (
  input logic clk_i,
  input logic reset_i,
  input logic push_i,
  input logic pop_i,
  input logic req_credit_i,
  input logic resp_valid_i,
  input logic resp_credit_i
);

  timeunit 1ns;
  timeprecision 1ns;

  localparam int CW = alu_pkg::REQ_CNT_W;

  logic [CW-1:0] occupancy;   // mirrors the queue fill level
  int            resp_avail;  // downstream credits seen at the ports

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      occupancy <= '0;
    end else begin
      occupancy <= occupancy + CW'(push_i) - CW'(pop_i);
    end
  end

  // granted credits minus responses already sent
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_avail <= alu_pkg::RESP_CREDITS;
    end else begin
      resp_avail <= resp_avail + int'(resp_credit_i) - int'(resp_valid_i);
    end
  end

  push_not_full: assert property (@(posedge clk_i) disable iff (reset_i)
    push_i |-> (occupancy < alu_pkg::REQ_DEPTH))
    else $error("request pushed into a full queue");

  resp_needs_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_i |-> (resp_avail > 0))
    else $error("response sent without a downstream credit");

  quiet_after_reset: assert property (@(posedge clk_i)
    $fell(reset_i) |=> (!req_credit_i && !resp_valid_i))
    else $error("credit or response output active right after reset");

endmodule

bind exec_unit exec_unit_assert u_assert (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .push_i        (req_valid_i),
  .pop_i         (pop),
  .req_credit_i  (req_credit_o),
  .resp_valid_i  (resp_valid_o),
  .resp_credit_i (resp_credit_i)
);

`default_nettype wire

// ==== verification/exec_unit_tb.sv ====
`default_nettype none

module exec_unit_tb;

  timeunit 1ns;
  timeprecision 1ns;

  localparam int TOTAL_REQS  = 80;    // requests over all tests, rounded up
  localparam int CYCLE_BOUND = 40;    // generous cycles per request
  localparam int TIMEOUT_NS  = TOTAL_REQS * CYCLE_BOUND * 100;

  logic               clk;
  logic               reset;
  logic               req_valid;
  alu_pkg::alu_req_t  req;
  logic               req_credit;
  logic               resp_valid;
  alu_pkg::alu_resp_t resp;
  logic               resp_credit;

  integer                   seed = 32'hefef;
  int                       errors = 0;
  int                       checks = 0;
  int                       tests_run = 0;
  int                       resp_count = 0;
  int                       credit_pulses = 0;
  int                       up_used = 0;        // upstream credits spent
  int                       up_returned = 0;    // upstream credits given back
  int                       credit_owed = 0;    // downstream credits still to return
  bit                       auto_return = 1'b0;
  logic [alu_pkg::TAG_W-1:0] next_tag = '0;
  alu_pkg::alu_resp_t       exp_q [$];
  alu_pkg::alu_resp_t       exp_r;

  clock_gen u_clock_gen (
    .clk_o (clk)
  );

  exec_unit dut0 (
    .clk_i         (clk),
    .reset_i       (reset),
    .req_valid_i   (req_valid),
    .req_i         (req),
    .req_credit_o  (req_credit),
    .resp_valid_o  (resp_valid),
    .resp_o        (resp),
    .resp_credit_i (resp_credit)
  );

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // expected response straight from the result and flag rules
  function automatic alu_pkg::alu_resp_t expected_resp(input alu_pkg::alu_req_t r);
    alu_pkg::alu_resp_t e;
    logic [63:0]        a;
    logic [63:0]        b;
    logic [64:0]        wide;
    logic [63:0]        sum;
    bit                 arith;
    a     = r.a;
    b     = r.b.value;
    e     = '0;
    e.tag = r.tag;
    sum   = '0;
    arith = 1'b1;
    if (r.op == alu_pkg::ADD) begin
      wide       = {1'b0, a} + {1'b0, b};
      sum        = wide[63:0];
      e.flags.cf = wide[64];
      e.flags.of = (a[63] == b[63]) && (sum[63] != a[63]);
    end else if (r.op == alu_pkg::SUB || r.op == alu_pkg::SLT || r.op == alu_pkg::SLTU) begin
      sum        = a - b;
      e.flags.cf = (a < b);   // borrow
      e.flags.of = (a[63] != b[63]) && (sum[63] != a[63]);
    end else begin
      arith = 1'b0;
    end
    if (arith) begin
      e.flags.zf = (sum == 64'd0);
      e.flags.sf = sum[63];
    end
    case (r.op)
      alu_pkg::ADD, alu_pkg::SUB: e.result = sum;
      alu_pkg::SLL:  e.result = a << b[5:0];
      alu_pkg::SRL:  e.result = a >> b[5:0];
      alu_pkg::SRA:  e.result = $signed(a) >>> b[5:0];
      alu_pkg::AND:  e.result = a & b;
      alu_pkg::OR:   e.result = a | b;
      alu_pkg::XOR:  e.result = a ^ b;
      alu_pkg::SLT:  e.result = {63'd0, $signed(a) < $signed(b)};
      alu_pkg::SLTU: e.result = {63'd0, a < b};
      default:       e.result = 64'd0;
    endcase
    return e;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic int up_avail();
    return alu_pkg::REQ_DEPTH + up_returned - up_used;
  endfunction

  // issue one request, waiting for an upstream credit first
  task automatic send(input alu_pkg::alu_op_e op, input logic [63:0] a,
                      input logic [63:0] b);
    alu_pkg::alu_req_t r;
    r.op      = op;
    r.a       = a;
    r.b.value = b;
    r.tag     = next_tag;
    @(posedge clk);
    while (up_avail() <= 0) begin
      @(negedge clk);
      req_valid = 1'b0;   // no push while out of credits
      @(posedge clk);
    end
    @(negedge clk);
    req_valid = 1'b1;
    req       = r;
    up_used++;
    next_tag++;
    exp_q.push_back(expected_resp(r));
  endtask

  task automatic idle();
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic drain();
    idle();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
  endtask

  task automatic report(input string name, input int e0);
    tests_run++;
    if (errors == e0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - e0);
    end
  endtask

  // response checker and downstream credit return
  always @(negedge clk) begin
    if (req_credit === 1'b1) begin
      credit_pulses++;
      up_returned++;
    end
    if (resp_valid === 1'b1) begin
      resp_count++;
      assert (exp_q.size() != 0) else begin
        $display("response arrived with no request outstanding");
        errors++;
      end
      if (exp_q.size() != 0) begin
        exp_r = exp_q.pop_front();
        check_value("resp_o.result", resp.result, exp_r.result);
        check_value("resp_o.flags", 64'(resp.flags), 64'(exp_r.flags));
        check_value("resp_o.tag", 64'(resp.tag), 64'(exp_r.tag));
      end
      if (auto_return) begin
        credit_owed++;
      end
    end
    resp_credit = (credit_owed > 0);
    if (credit_owed > 0) begin
      credit_owed--;
    end
  end

  task automatic test_reset();
    int e0;
    int r0;
    e0 = errors;
    r0 = resp_count;
    repeat (3) begin
      @(negedge clk);
      check_value("resp_valid_o", 64'(resp_valid), 64'd0);
      check_value("req_credit_o", 64'(req_credit), 64'd0);
    end
    for (int i = 0; i < alu_pkg::REQ_DEPTH; i++) begin
      send(alu_pkg::ADD, rand64(), rand64());
    end
    idle();
    repeat (10) @(posedge clk);   // only the reset credits may drain
    check_value("response count", 64'(resp_count - r0), 64'(alu_pkg::RESP_CREDITS));
    @(posedge clk);
    credit_owed += alu_pkg::RESP_CREDITS;
    auto_return = 1'b1;
    drain();
    report("reset state", e0);
  endtask

  task automatic test_arith();
    int e0;
    e0 = errors;
    send(alu_pkg::SUB, 64'h8000_0000_0000_0000, 64'd1);   // signed overflow
    send(alu_pkg::ADD, 64'hffff_ffff_ffff_ffff, 64'd1);   // carry and zero
    send(alu_pkg::ADD, 64'h7fff_ffff_ffff_ffff, 64'd1);
    send(alu_pkg::SUB, 64'h0000_0000_0000_1234, 64'h0000_0000_0000_1234);
    send(alu_pkg::SUB, 64'd0, 64'd1);                     // borrow
    for (int i = 0; i < 8; i++) begin
      send(alu_pkg::ADD, rand64(), rand64());
      send(alu_pkg::SUB, rand64(), rand64());
    end
    drain();
    report("arithmetic and flags", e0);
  endtask

  task automatic test_shift();
    int               e0;
    alu_pkg::alu_op_e op;
    e0 = errors;
    for (int k = 0; k < 3; k++) begin
      op = (k == 0) ? alu_pkg::SLL : (k == 1) ? alu_pkg::SRL : alu_pkg::SRA;
      send(op, 64'hf0f0_0000_0000_0f0f, 64'hffff_ffff_ffff_ffc0);   // shamt 0
      send(op, 64'h8000_0000_0000_0001, 64'h0000_0000_0000_ff7f);   // shamt 63
      for (int i = 0; i < 3; i++) begin
        send(op, rand64() | 64'h8000_0000_0000_0000, rand64());
        send(op, rand64(), rand64());
      end
    end
    drain();
    report("shifts", e0);
  endtask

  task automatic test_logic_compare();
    int               e0;
    alu_pkg::alu_op_e op;
    e0 = errors;
    for (int k = 0; k < 3; k++) begin
      op = (k == 0) ? alu_pkg::AND : (k == 1) ? alu_pkg::OR : alu_pkg::XOR;
      for (int i = 0; i < 4; i++) begin
        send(op, rand64(), rand64());
      end
    end
    for (int k = 0; k < 2; k++) begin
      op = (k == 0) ? alu_pkg::SLT : alu_pkg::SLTU;
      send(op, 64'hffff_ffff_ffff_ffff, 64'd1);   // signed and unsigned disagree
      send(op, 64'd1, 64'hffff_ffff_ffff_ffff);
      send(op, 64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff);
      send(op, 64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000);
      send(op, 64'd5, 64'd5);
    end
    drain();
    report("logic and compare", e0);
  endtask

  task automatic test_credit_flow();
    int e0;
    int r0;
    int p0;
    e0 = errors;
    r0 = resp_count;
    p0 = credit_pulses;
    for (int i = 0; i < alu_pkg::REQ_DEPTH; i++) begin
      send(alu_pkg::XOR, rand64(), rand64());   // back to back
    end
    drain();
    check_value("req_credit_o pulses", 64'(credit_pulses - p0), 64'(resp_count - r0));
    check_value("response count", 64'(resp_count - r0), 64'(alu_pkg::REQ_DEPTH));
    report("upstream credit flow", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    int r0;
    e0 = errors;
    r0 = resp_count;
    auto_return = 1'b0;
    for (int i = 0; i < alu_pkg::REQ_DEPTH; i++) begin
      send(alu_pkg::SUB, rand64(), rand64());
    end
    idle();
    repeat (10) @(posedge clk);
    check_value("response count", 64'(resp_count - r0), 64'(alu_pkg::RESP_CREDITS));
    for (int i = 0; i < alu_pkg::REQ_DEPTH - alu_pkg::RESP_CREDITS; i++) begin
      @(posedge clk);
      credit_owed++;   // one credit releases one result
      repeat (6) @(posedge clk);
      check_value("response count", 64'(resp_count - r0),
                  64'(alu_pkg::RESP_CREDITS + i + 1));
    end
    @(posedge clk);
    credit_owed += alu_pkg::RESP_CREDITS;
    auto_return = 1'b1;
    drain();
    report("back-pressure", e0);
  endtask

  initial begin
    reset       = 1'b1;
    req_valid   = 1'b0;
    req         = '0;
    resp_credit = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset();
    test_arith();
    test_shift();
    test_logic_compare();
    test_credit_flow();
    test_backpressure();
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired before the tests finished");
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
verilog/alu_pkg.sv
verilog/alu_adder.sv
verilog/alu_shifter.sv
verilog/alu.sv
verilog/req_fifo.sv
verilog/exec_unit.sv
verification/clock_gen.sv
verification/exec_unit_assert.sv
verification/exec_unit_tb.sv

// ==== Makefile ====
TOP = exec_unit_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
		--top-module $(TOP) -f all.f -Mdir obj_dir -o sim_bin
	./obj_dir/sim_bin | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
